//--- rv_exu.f
+incdir+dv
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/exu_ctrl_if.sv
rtl/rv_exu_decode.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_lsu.sv
rtl/rv_exu.sv
dv/rv_exu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rv_exu_tb -f rv_exu.f \
  --Mdir build -o rv_exu_sim > build.log 2>&1 \
  && ./build/rv_exu_sim > sim.log 2>&1 \
  || { echo "compile or run error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

//--- dv/rv_exu_tb_model.svh
`ifndef RV_EXU_TB_MODEL_SVH
`define RV_EXU_TB_MODEL_SVH

// architectural mirror, updated once per accepted instruction
logic [XLEN-1:0] m_regs [32];
logic [XLEN-1:0] m_mem  [DMEM_WORDS];

function automatic logic [XLEN-1:0] sext32(input logic [31:0] w);
  return {{32{w[31]}}, w};
endfunction

function automatic void model_reset();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
endfunction

// expected dnpc, write enable and write value for one instruction
function automatic void predict(input logic v, input rv_op_e o,
    input logic [REG_AW-1:0] s1, input logic [REG_AW-1:0] s2,
    input logic [XLEN-1:0] im, input logic [XLEN-1:0] p,
    output logic [XLEN-1:0] npc, output logic en, output logic [XLEN-1:0] data);
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [XLEN-1:0] addr;
  logic [XLEN-1:0] word;
  logic [5:0]      bo;
  a    = m_regs[s1];
  b    = m_regs[s2];
  addr = a + im;
  word = m_mem[addr[DMEM_AW+2:3]];
  bo   = {addr[2:0], 3'b000};
  en   = v && !(o inside {OP_NOP, OP_BNE, OP_SH, OP_SD, OP_EBREAK});
  case (o)
    OP_ADD:          data = a + b;
    OP_SUB:          data = a - b;
    OP_ADDW:         data = sext32(a[31:0] + b[31:0]);
    OP_SLLW:         data = sext32(a[31:0] << b[4:0]);
    OP_SLLI:         data = a << im[5:0];
    OP_ADDI:         data = a + im;
    OP_SLTIU:        data = (a < im) ? 64'd1 : 64'd0;
    OP_LUI:          data = im;
    OP_AUIPC:        data = p + im;
    OP_JAL, OP_JALR: data = p + 64'd4;
    OP_LD:           data = word;
    OP_LW:           data = sext32(addr[2] ? word[63:32] : word[31:0]);
    OP_LBU:          data = {56'h0, word[bo +: 8]};
    default:         data = '0;
  endcase
  npc = p + 64'd4;
  if (v && o == OP_JAL) begin
    npc = p + im;
  end else if (v && o == OP_JALR) begin
    npc = (a + im) & ~64'd1;
  end else if (v && o == OP_BNE && a != b) begin
    npc = p + im;
  end
endfunction

function automatic void commit(input logic v, input rv_op_e o, input logic [REG_AW-1:0] d,
    input logic [REG_AW-1:0] s1, input logic [REG_AW-1:0] s2, input logic [XLEN-1:0] im,
    input logic en, input logic [XLEN-1:0] data);
  logic [XLEN-1:0] addr;
  logic [5:0]      bo;
  addr = m_regs[s1] + im;
  bo   = {addr[2:0], 3'b000};
  if (v && o == OP_SD) begin
    m_mem[addr[DMEM_AW+2:3]] = m_regs[s2];
  end
  if (v && o == OP_SH) begin
    m_mem[addr[DMEM_AW+2:3]][bo +: 16] = m_regs[s2][15:0];
  end
  if (en && d != '0) begin
    m_regs[d] = data;
  end
endfunction

`endif

//--- dv/rv_exu_tb.sv
`timescale 1ns/1ns

module rv_exu_tb;
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  // cycles issued by the program below
  localparam int PROG_CYCLES = 152;
  localparam int TIMEOUT_NS  = PROG_CYCLES * 10 + 500;

  logic              clk;
  logic              rst_n;
  logic              valid;
  rv_op_e            op;
  logic [REG_AW-1:0] rd;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [XLEN-1:0]   imm;
  logic [XLEN-1:0]   pc;
  logic [XLEN-1:0]   dnpc;
  logic              wb_en;
  logic [REG_AW-1:0] wb_rd;
  logic [XLEN-1:0]   wb_data;
  logic              halt;
  logic              halt_a0_zero;

  integer            seed;
  int                errors;
  int                checks;
  logic [XLEN-1:0]   pc_drv;
  logic              exp_halt;
  logic              exp_a0_zero;
  rv_op_e            arith_ops [7] = '{OP_ADD, OP_SUB, OP_SLTIU, OP_SLLI,
                                       OP_ADDW, OP_SLLW, OP_AUIPC};

  `include "rv_exu_tb_model.svh"

  rv_exu i_dut (.*);

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    checks++;
    assert (act === exp) else begin
      $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      errors++;
    end
  endtask

  function automatic logic [XLEN-1:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return {{32{r[31]}}, r};
  endfunction

  // drives one cycle after the edge and checks at the falling edge
  task automatic step(input logic v, input rv_op_e o, input logic [REG_AW-1:0] d,
                      input logic [REG_AW-1:0] s1, input logic [REG_AW-1:0] s2,
                      input logic [XLEN-1:0] im);
    logic [XLEN-1:0] e_dnpc;
    logic            e_en;
    logic [XLEN-1:0] e_data;
    @(posedge clk);
    #1;
    valid = v;
    op    = o;
    rd    = d;
    rs1   = s1;
    rs2   = s2;
    imm   = im;
    pc    = pc_drv;
    @(negedge clk);
    predict(v, o, s1, s2, im, pc_drv, e_dnpc, e_en, e_data);
    check_value("halt", XLEN'(exp_halt), XLEN'(halt));
    if (exp_halt) begin
      check_value("halt_a0_zero", XLEN'(exp_a0_zero), XLEN'(halt_a0_zero));
    end
    check_value("dnpc", e_dnpc, dnpc);
    check_value("wb_en", XLEN'(e_en), XLEN'(wb_en));
    if (e_en) begin
      check_value("wb_rd", XLEN'(d), XLEN'(wb_rd));
      check_value("wb_data", e_data, wb_data);
    end
    exp_halt = v && (o == OP_EBREAK);
    if (exp_halt) begin
      exp_a0_zero = (m_regs[10] == '0);
    end
    commit(v, o, d, s1, s2, im, e_en, e_data);
    pc_drv = pc_drv + 64'd4;
  endtask

  task automatic idle_cycle();
    step(1'b0, OP_NOP, '0, '0, '0, '0);
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    // a valid ebreak during reset must not raise halt
    valid = 1'b1;
    op    = OP_EBREAK;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    valid = 1'b0;
    check_value("halt", '0, XLEN'(halt));
    model_reset();
    exp_halt = 1'b0;
  endtask

  // addi x0, xi, 0 shows every register value on wb_data
  task automatic read_back_regs();
    for (int i = 1; i < 32; i++) begin
      step(1'b1, OP_ADDI, '0, REG_AW'(i), '0, '0);
    end
  endtask

  initial begin
    logic [31:0] r;
    rv_op_e      o;
    clk    = 1'b0;
    valid  = 1'b0;
    op     = OP_NOP;
    rd     = '0;
    rs1    = '0;
    rs2    = '0;
    imm    = '0;
    pc     = '0;
    seed   = 32'he0d4;
    errors = 0;
    checks = 0;
    pc_drv = 64'h8000_0000;
    apply_reset();
    read_back_regs();
    for (int i = 1; i <= 8; i++) begin
      step(1'b1, OP_ADDI, REG_AW'(i), '0, '0, rand_word());
      step(1'b1, OP_LUI, REG_AW'(i + 8), '0, '0, rand_word() & ~64'hfff);
    end
    for (int k = 0; k < 21; k++) begin
      r = $random(seed);
      o = arith_ops[k % 7];
      if (o == OP_AUIPC) begin
        pc_drv = {32'h0, r[31:2], 2'b00};
      end
      step(1'b1, o, REG_AW'(17 + k % 8), {1'b0, r[3:0]} + 5'd1, {1'b0, r[7:4]} + 5'd1,
           (o == OP_SLLI) ? {58'h0, r[13:8]} : rand_word());
    end
    // word forms with bit 31 set in the result
    step(1'b1, OP_ADDI, 5'd25, '0, '0, 64'h7fff_ffff);
    step(1'b1, OP_ADDW, 5'd26, 5'd25, 5'd25, '0);
    step(1'b1, OP_SLLW, 5'd26, 5'd25, 5'd25, '0);
    step(1'b1, OP_ADD, '0, 5'd1, 5'd2, '0);
    step(1'b1, OP_ADD, 5'd27, 5'd0, 5'd3, '0);
    step(1'b1, OP_ADDI, 5'd28, '0, '0, 64'h100);
    step(1'b1, OP_SD, '0, 5'd28, 5'd1, '0);
    step(1'b1, OP_SD, '0, 5'd28, 5'd2, 64'h8);
    step(1'b1, OP_SD, '0, 5'd28, 5'd9, 64'hffff_ffff_ffff_fff8);
    step(1'b1, OP_LD, 5'd29, 5'd28, '0, 64'hffff_ffff_ffff_fff8);
    step(1'b1, OP_SH, '0, 5'd28, 5'd3, 64'h2);
    step(1'b1, OP_SH, '0, 5'd28, 5'd4, 64'he);
    for (int k = 0; k < 16; k += 8) begin
      step(1'b1, OP_LD, 5'd29, 5'd28, '0, XLEN'(k));
    end
    for (int k = 0; k < 16; k += 4) begin
      step(1'b1, OP_LW, 5'd29, 5'd28, '0, XLEN'(k));
    end
    for (int k = 0; k < 8; k++) begin
      step(1'b1, OP_LBU, 5'd30, 5'd28, '0, XLEN'(k));
    end
    // nothing may change while valid is low
    step(1'b0, OP_SD, '0, 5'd28, 5'd5, '0);
    step(1'b0, OP_JAL, 5'd1, '0, '0, rand_word());
    step(1'b1, OP_LD, 5'd29, 5'd28, '0, '0);
    step(1'b1, OP_ADD, 5'd27, 5'd1, 5'd0, '0);
    pc_drv = 64'h8000_1000;
    step(1'b1, OP_JAL, 5'd30, '0, '0, rand_word());
    step(1'b1, OP_JAL, 5'd30, '0, '0, 64'hffff_ffff_ffff_fff0);
    step(1'b1, OP_JALR, 5'd31, 5'd28, '0, 64'h11);
    step(1'b1, OP_JALR, 5'd31, 5'd1, '0, rand_word());
    step(1'b1, OP_BNE, '0, 5'd1, 5'd2, 64'h40);
    step(1'b1, OP_BNE, '0, 5'd3, 5'd3, 64'h40);
    step(1'b1, OP_BNE, '0, 5'd0, 5'd0, 64'h80);
    step(1'b1, OP_ADDI, 5'd10, '0, '0, '0);
    step(1'b1, OP_EBREAK, '0, '0, '0, '0);
    idle_cycle();
    step(1'b1, OP_ADDI, 5'd10, '0, '0, 64'h5);
    step(1'b1, OP_EBREAK, '0, '0, '0, '0);
    step(1'b0, OP_EBREAK, '0, '0, '0, '0);
    idle_cycle();
    // registers clear on reset while memory keeps its contents
    apply_reset();
    read_back_regs();
    step(1'b1, OP_ADDI, 5'd28, '0, '0, 64'h100);
    step(1'b1, OP_LD, 5'd29, 5'd28, '0, 64'h8);
    idle_cycle();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: program did not finish within %0d ns", TIMEOUT_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- rtl/rv_exu.sv
`timescale 1ns/1ns

module rv_exu (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           valid,
  input  rv_isa_pkg::rv_op_e             op,
  input  logic [rv_core_pkg::REG_AW-1:0] rd,
  input  logic [rv_core_pkg::REG_AW-1:0] rs1,
  input  logic [rv_core_pkg::REG_AW-1:0] rs2,
  input  logic [rv_core_pkg::XLEN-1:0]   imm,
  input  logic [rv_core_pkg::XLEN-1:0]   pc,
  output logic [rv_core_pkg::XLEN-1:0]   dnpc,
  output logic                           wb_en,
  output logic [rv_core_pkg::REG_AW-1:0] wb_rd,
  output logic [rv_core_pkg::XLEN-1:0]   wb_data,
  output logic                           halt,
  output logic                           halt_a0_zero
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] a0;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] br_target;

  exu_ctrl_if ctrl ();

  rv_exu_decode u_decode (
    .op   (op),
    .ctrl (ctrl)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .wen     (wb_en),
    .waddr   (rd),
    .raddr_a (rs1),
    .raddr_b (rs2),
    .wdata   (wb_data),
    .rdata_a (src1),
    .rdata_b (src2),
    .a0      (a0)
  );

  rv_alu u_alu (
    .ctrl   (ctrl),
    .src1   (src1),
    .src2   (src2),
    .imm    (imm),
    .pc     (pc),
    .result (alu_result)
  );

  rv_lsu u_lsu (
    .clk        (clk),
    .valid      (valid),
    .ctrl       (ctrl),
    .base       (src1),
    .offset     (imm),
    .store_data (src2),
    .load_data  (load_data)
  );

  assign link      = pc + 64'd4;
  assign br_target = pc + imm;

  always_comb begin
    case (ctrl.wb_sel)
      WB_ALU:   wb_data = alu_result;
      WB_ALU_W: wb_data = {{(XLEN-32){alu_result[31]}}, alu_result[31:0]};
      WB_IMM:   wb_data = imm;
      WB_LINK:  wb_data = link;
      WB_MEM:   wb_data = load_data;
      default:  wb_data = alu_result;
    endcase
  end

  // rd of zero still reports wb_en, the regfile drops the write
  assign wb_en = valid & ctrl.reg_wen;
  assign wb_rd = rd;

  always_comb begin
    if (!valid) begin
      dnpc = link;
    end else if (ctrl.is_jal) begin
      dnpc = alu_result;
    end else if (ctrl.is_jalr) begin
      dnpc = {alu_result[XLEN-1:1], 1'b0};
    end else if (ctrl.is_branch && (src1 != src2)) begin
      dnpc = br_target;
    end else begin
      dnpc = link;
    end
  end

  // one-cycle halt pulse, a0 sampled in the ebreak cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halt         <= 1'b0;
      halt_a0_zero <= 1'b0;
    end else begin
      halt <= valid & ctrl.is_ebreak;
      if (valid && ctrl.is_ebreak) begin
        halt_a0_zero <= (a0 == '0);
      end
    end
  end

endmodule

//--- rtl/rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu (
  input  logic                         clk,
  input  logic                         valid,
  exu_ctrl_if.lsu                      ctrl,
  input  logic [rv_core_pkg::XLEN-1:0] base,
  input  logic [rv_core_pkg::XLEN-1:0] offset,
  input  logic [rv_core_pkg::XLEN-1:0] store_data,
  output logic [rv_core_pkg::XLEN-1:0] load_data
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [XLEN-1:0]   mem [DMEM_WORDS];

  logic [XLEN-1:0]   addr;
  logic [DMEM_AW-1:0] word_idx;
  logic [2:0]        byte_off;
  logic [5:0]        bit_off;
  logic [XLEN-1:0]   word;
  logic [XLEN/8-1:0] wmask;
  logic [XLEN-1:0]   wdata;
  logic [31:0]       ld_half;
  logic [7:0]        ld_byte;

  assign addr     = base + offset;
  assign word_idx = addr[DMEM_AW+2:3];
  assign byte_off = addr[2:0];
  assign bit_off  = {byte_off, 3'b000};

  // store lanes and data aligned to the byte offset
  always_comb begin
    case (ctrl.mem_op)
      MEM_SH: begin
        wmask = 8'b0000_0011 << byte_off;
        wdata = {{(XLEN-16){1'b0}}, store_data[15:0]} << bit_off;
      end
      MEM_SD: begin
        wmask = '1;
        wdata = store_data;
      end
      default: begin
        wmask = '0;
        wdata = store_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (valid) begin
      for (int i = 0; i < XLEN/8; i++) begin
        if (wmask[i]) begin
          mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  assign word = mem[word_idx];

  // addr bit 2 picks the upper 32 bits
  assign ld_half = addr[2] ? word[63:32] : word[31:0];
  assign ld_byte = word[bit_off +: 8];

  always_comb begin
    case (ctrl.mem_op)
      MEM_LD:  load_data = word;
      MEM_LW:  load_data = {{(XLEN-32){ld_half[31]}}, ld_half};
      MEM_LBU: load_data = {{(XLEN-8){1'b0}}, ld_byte};
      default: load_data = '0;
    endcase
  end

endmodule

//--- rtl/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
  exu_ctrl_if.alu                       ctrl,
  input  logic [rv_core_pkg::XLEN-1:0] src1,
  input  logic [rv_core_pkg::XLEN-1:0] src2,
  input  logic [rv_core_pkg::XLEN-1:0] imm,
  input  logic [rv_core_pkg::XLEN-1:0] pc,
  output logic [rv_core_pkg::XLEN-1:0] result
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;

  assign op_a = ctrl.a_sel_pc ? pc : src1;

  always_comb begin
    case (ctrl.b_sel)
      OPB_RS2: op_b = src2;
      OPB_IMM: op_b = imm;
      // word shifts only use five bits of rs2
      OPB_SHW: op_b = {{(XLEN-5){1'b0}}, src2[4:0]};
      default: op_b = src2;
    endcase
  end

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  result = op_a + op_b;
      ALU_SUB:  result = op_a - op_b;
      // slli shamt is imm[5:0]
      ALU_SLL:  result = op_a << op_b[5:0];
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, (op_a < op_b)};
      default:  result = op_a + op_b;
    endcase
  end

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wen,
  input  logic [rv_core_pkg::REG_AW-1:0] waddr,
  input  logic [rv_core_pkg::REG_AW-1:0] raddr_a,
  input  logic [rv_core_pkg::REG_AW-1:0] raddr_b,
  input  logic [rv_core_pkg::XLEN-1:0]   wdata,
  output logic [rv_core_pkg::XLEN-1:0]   rdata_a,
  output logic [rv_core_pkg::XLEN-1:0]   rdata_b,
  output logic [rv_core_pkg::XLEN-1:0]   a0
);
  import rv_core_pkg::*;

  logic [XLEN-1:0] regs [2**REG_AW];

  // x0 is cleared by reset and never written afterwards
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

  // x10 for the halt code
  assign a0 = regs[10];

endmodule

//--- rtl/rv_exu_decode.sv
`timescale 1ns/1ns

module rv_exu_decode (
  input  rv_isa_pkg::rv_op_e op,
  exu_ctrl_if.decode         ctrl
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  always_comb begin
    ctrl.alu_op    = ALU_ADD;
    ctrl.a_sel_pc  = 1'b0;
    ctrl.b_sel     = OPB_RS2;
    ctrl.mem_op    = MEM_NONE;
    ctrl.wb_sel    = WB_ALU;
    ctrl.reg_wen   = 1'b0;
    ctrl.is_branch = 1'b0;
    ctrl.is_jal    = 1'b0;
    ctrl.is_jalr   = 1'b0;
    ctrl.is_ebreak = 1'b0;

    case (op)
      OP_ADD: begin
        ctrl.reg_wen = 1'b1;
      end
      OP_SUB: begin
        ctrl.alu_op  = ALU_SUB;
        ctrl.reg_wen = 1'b1;
      end
      OP_ADDW: begin
        ctrl.wb_sel  = WB_ALU_W;
        ctrl.reg_wen = 1'b1;
      end
      OP_SLLW: begin
        ctrl.alu_op  = ALU_SLL;
        ctrl.b_sel   = OPB_SHW;
        ctrl.wb_sel  = WB_ALU_W;
        ctrl.reg_wen = 1'b1;
      end
      OP_SLLI: begin
        ctrl.alu_op  = ALU_SLL;
        ctrl.b_sel   = OPB_IMM;
        ctrl.reg_wen = 1'b1;
      end
      OP_ADDI: begin
        ctrl.b_sel   = OPB_IMM;
        ctrl.reg_wen = 1'b1;
      end
      OP_SLTIU: begin
        ctrl.alu_op  = ALU_SLTU;
        ctrl.b_sel   = OPB_IMM;
        ctrl.reg_wen = 1'b1;
      end
      OP_LUI: begin
        ctrl.wb_sel  = WB_IMM;
        ctrl.reg_wen = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.a_sel_pc = 1'b1;
        ctrl.b_sel    = OPB_IMM;
        ctrl.reg_wen  = 1'b1;
      end
      // alu forms the jump target, rd gets the link address
      OP_JAL: begin
        ctrl.a_sel_pc = 1'b1;
        ctrl.b_sel    = OPB_IMM;
        ctrl.wb_sel   = WB_LINK;
        ctrl.reg_wen  = 1'b1;
        ctrl.is_jal   = 1'b1;
      end
      OP_JALR: begin
        ctrl.b_sel   = OPB_IMM;
        ctrl.wb_sel  = WB_LINK;
        ctrl.reg_wen = 1'b1;
        ctrl.is_jalr = 1'b1;
      end
      OP_BNE: begin
        ctrl.is_branch = 1'b1;
      end
      OP_LD: begin
        ctrl.mem_op  = MEM_LD;
        ctrl.wb_sel  = WB_MEM;
        ctrl.reg_wen = 1'b1;
      end
      OP_LW: begin
        ctrl.mem_op  = MEM_LW;
        ctrl.wb_sel  = WB_MEM;
        ctrl.reg_wen = 1'b1;
      end
      OP_LBU: begin
        ctrl.mem_op  = MEM_LBU;
        ctrl.wb_sel  = WB_MEM;
        ctrl.reg_wen = 1'b1;
      end
      OP_SH: begin
        ctrl.mem_op = MEM_SH;
      end
      OP_SD: begin
        ctrl.mem_op = MEM_SD;
      end
      OP_EBREAK: begin
        ctrl.is_ebreak = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- rtl/exu_ctrl_if.sv
`timescale 1ns/1ns

interface exu_ctrl_if;
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  alu_op_e  alu_op;
  logic     a_sel_pc;
  opb_sel_e b_sel;
  mem_op_e  mem_op;
  wb_sel_e  wb_sel;
  logic     reg_wen;
  logic     is_branch;
  logic     is_jal;
  logic     is_jalr;
  logic     is_ebreak;

  modport decode (
    output alu_op, a_sel_pc, b_sel, mem_op, wb_sel, reg_wen,
           is_branch, is_jal, is_jalr, is_ebreak
  );

  modport alu (
    input alu_op, a_sel_pc, b_sel
  );

  modport lsu (
    input mem_op
  );

  // writeback and next pc selection
  modport wb (
    input wb_sel, reg_wen, is_branch, is_jal, is_jalr, is_ebreak
  );

endinterface

//--- rtl/rv_core_pkg.sv
package rv_core_pkg;

  localparam int XLEN       = 64;
  localparam int REG_AW     = 5;

  // data memory, counted in 64-bit words
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = 8;

  // writeback source
  typedef enum logic [2:0] {
    WB_ALU   = 3'd0,
    WB_ALU_W = 3'd1,
    WB_IMM   = 3'd2,
    WB_LINK  = 3'd3,
    WB_MEM   = 3'd4
  } wb_sel_e;

endpackage

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

  // executed opcode, already decoded upstream
  typedef enum logic [4:0] {
    OP_NOP    = 5'd0,
    OP_ADD    = 5'd1,
    OP_SUB    = 5'd2,
    OP_ADDW   = 5'd3,
    OP_SLLW   = 5'd4,
    OP_SLLI   = 5'd5,
    OP_ADDI   = 5'd6,
    OP_SLTIU  = 5'd7,
    OP_LUI    = 5'd8,
    OP_AUIPC  = 5'd9,
    OP_JAL    = 5'd10,
    OP_JALR   = 5'd11,
    OP_BNE    = 5'd12,
    OP_LD     = 5'd13,
    OP_LW     = 5'd14,
    OP_LBU    = 5'd15,
    OP_SH     = 5'd16,
    OP_SD     = 5'd17,
    OP_EBREAK = 5'd18
  } rv_op_e;

  typedef enum logic [1:0] {
    ALU_ADD  = 2'd0,
    ALU_SUB  = 2'd1,
    ALU_SLL  = 2'd2,
    ALU_SLTU = 2'd3
  } alu_op_e;

  typedef enum logic [2:0] {
    MEM_NONE = 3'd0,
    MEM_LD   = 3'd1,
    MEM_LW   = 3'd2,
    MEM_LBU  = 3'd3,
    MEM_SH   = 3'd4,
    MEM_SD   = 3'd5
  } mem_op_e;

  // operand b source, OPB_SHW is the word shift amount rs2[4:0]
  typedef enum logic [1:0] {
    OPB_RS2 = 2'd0,
    OPB_IMM = 2'd1,
    OPB_SHW = 2'd2
  } opb_sel_e;

endpackage
